//--- sram_switch_cfg.svh
`ifndef SRAM_SWITCH_CFG_SVH
`define SRAM_SWITCH_CFG_SVH

// Bank count and the width of a bank index.
`define SW_BANKS 32
`define SW_BANK_W 5

// Packet length in bytes, up to 511.
`define SW_LEN_W 9

// Free space per bank, counted in 8-byte cells.
`define SW_FREE_W 11
`define SW_BANK_CELLS 1024

// Packets stored per bank.
`define SW_CNT_W 9

// Write ports sharing the bank table.
`define SW_PORTS 2

`endif

//--- sram_switch_pkg.sv
`default_nettype none

`include "sram_switch_cfg.svh"

package sram_switch_pkg;

    // Matcher progress through the bank table.
    // Done and fail hold until the enable falls.
    typedef enum logic [1:0] {
        st_idle,
        st_scan,
        st_done,
        st_fail
    } scan_state_t;

    // Update applied to one bank of the table.
    typedef enum logic [1:0] {
        op_none,
        op_commit,
        op_release
    } table_op_t;

    // Status of one bank as seen by a scanning port.
    // Accessible comes from the disable mask, not from a register.
    typedef struct packed {
        logic                  accessible;
        logic [`SW_FREE_W-1:0] free_space;
        logic [`SW_CNT_W-1:0]  packet_amount;
    } bank_status_t;

endpackage

`default_nettype wire

//--- bank_scan_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

interface bank_scan_if;

    // Four-phase request and grant to the shared table.
    logic arb_req;
    logic arb_ack;

    // Scan read, answered combinationally by the table.
    logic [`SW_BANK_W-1:0]        scan_bank;
    sram_switch_pkg::bank_status_t scan_status;

    // Single-cycle commit of the chosen bank.
    sram_switch_pkg::table_op_t commit_op;
    logic [`SW_BANK_W-1:0]      commit_bank;
    logic [`SW_FREE_W-1:0]      commit_cells;

    modport port_side (
        output arb_req, scan_bank, commit_op, commit_bank, commit_cells,
        input  arb_ack, scan_status
    );

    modport table_side (
        input  arb_req, scan_bank, commit_op, commit_bank, commit_cells,
        output arb_ack, scan_status
    );

endinterface

`default_nettype wire

//--- port_wr_sram_matcher.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

module port_wr_sram_matcher (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [`SW_BANK_W-1:0]         match_threshold,
    input  logic [`SW_LEN_W-1:0]          new_length,
    input  logic                          match_enable,
    input  sram_switch_pkg::bank_status_t matching_status,
    output logic [`SW_BANK_W-1:0]         matching_sram,
    output logic                          match_suc,
    output logic                          match_fail,
    output logic [`SW_BANK_W-1:0]         matching_best_sram
);

    sram_switch_pkg::scan_state_t state;
    logic [`SW_FREE_W-1:0]        cells_needed;
    logic [`SW_CNT_W-1:0]         max_amount;
    logic                         found;
    logic                         hit;
    logic                         last;

    // One cell per whole 8 bytes, plus one.
    assign cells_needed = {{(`SW_FREE_W-`SW_LEN_W+3){1'b0}}, new_length[`SW_LEN_W-1:3]} + 1'b1;

    // Bank qualifies and is at least as full as the best so far.
    // The >= lets a later index win a tie.
    assign hit = matching_status.accessible
              && (matching_status.free_space >= cells_needed)
              && (!found || (matching_status.packet_amount >= max_amount));

    assign last = (matching_sram == match_threshold);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= sram_switch_pkg::st_idle;
            matching_sram <= '0;
            found         <= 1'b0;
            match_suc     <= 1'b0;
            match_fail    <= 1'b0;
        end else begin
            // Result flags are one-cycle pulses.
            match_suc  <= 1'b0;
            match_fail <= 1'b0;
            if (!match_enable) begin
                // Grant gone, park at bank 0.
                state         <= sram_switch_pkg::st_idle;
                matching_sram <= '0;
                found         <= 1'b0;
            end else begin
                case (state)
                    sram_switch_pkg::st_idle: begin
                        state         <= sram_switch_pkg::st_scan;
                        matching_sram <= '0;
                        found         <= 1'b0;
                    end
                    sram_switch_pkg::st_scan: begin
                        if (hit) begin
                            found <= 1'b1;
                        end
                        if (last) begin
                            // Last bank seen this cycle still counts.
                            state      <= (found || hit) ? sram_switch_pkg::st_done
                                                         : sram_switch_pkg::st_fail;
                            match_suc  <= found || hit;
                            match_fail <= !(found || hit);
                        end else begin
                            matching_sram <= matching_sram + 1'b1;
                        end
                    end
                    sram_switch_pkg::st_done, sram_switch_pkg::st_fail: begin
                        // Hold until the port drops its grant.
                    end
                endcase
            end
        end
    end

    // Best bank and its count so far.
    always_ff @(posedge clk) begin
        if (match_enable && (state == sram_switch_pkg::st_scan) && hit) begin
            matching_best_sram <= matching_sram;
            max_amount         <= matching_status.packet_amount;
        end
    end

endmodule

`default_nettype wire

//--- port_wr_allocator.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

module port_wr_allocator (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_BANK_W-1:0] scan_limit,
    input  logic                  wr_req,
    input  logic [`SW_LEN_W-1:0]  wr_length,
    output logic                  wr_ack,
    output logic [`SW_BANK_W-1:0] wr_bank,
    output logic                  wr_fail,
    bank_scan_if.port_side        bus
);

    // Port sequence from outside request to completed handshake.
    typedef enum logic [2:0] {
        al_idle,
        al_wait,
        al_commit,
        al_drop,
        al_ack
    } alloc_state_t;

    alloc_state_t          state;
    logic [`SW_LEN_W-1:0]  length_q;
    logic [`SW_FREE_W-1:0] cells_q;
    logic                  arb_req_q;
    logic                  match_enable;
    logic                  match_suc;
    logic                  match_fail;
    logic [`SW_BANK_W-1:0] best_bank;

    // Matcher runs only while the table is ours.
    assign match_enable = arb_req_q && bus.arb_ack;

    assign bus.arb_req      = arb_req_q;
    assign bus.commit_op    = (state == al_commit) ? sram_switch_pkg::op_commit
                                                   : sram_switch_pkg::op_none;
    assign bus.commit_bank  = wr_bank;
    assign bus.commit_cells = cells_q;

    port_wr_sram_matcher i_port_wr_sram_matcher (
        .clk                (clk),
        .rst_n              (rst_n),
        .match_threshold    (scan_limit),
        .new_length         (length_q),
        .match_enable       (match_enable),
        .matching_status    (bus.scan_status),
        .matching_sram      (bus.scan_bank),
        .match_suc          (match_suc),
        .match_fail         (match_fail),
        .matching_best_sram (best_bank)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= al_idle;
            arb_req_q <= 1'b0;
            wr_ack    <= 1'b0;
            wr_fail   <= 1'b0;
        end else begin
            case (state)
                al_idle: begin
                    // Ask for the table one cycle after the request.
                    if (wr_req) begin
                        arb_req_q <= 1'b1;
                        state     <= al_wait;
                    end
                end
                al_wait: begin
                    if (match_suc) begin
                        wr_fail <= 1'b0;
                        state   <= al_commit;
                    end else if (match_fail) begin
                        // Nothing to commit, hand the table back now.
                        wr_fail   <= 1'b1;
                        arb_req_q <= 1'b0;
                        state     <= al_drop;
                    end
                end
                al_commit: begin
                    // Table applies the commit at this edge.
                    arb_req_q <= 1'b0;
                    state     <= al_drop;
                end
                al_drop: begin
                    // Wait for the grant to clear before answering.
                    if (!bus.arb_ack) begin
                        wr_ack <= 1'b1;
                        state  <= al_ack;
                    end
                end
                al_ack: begin
                    if (!wr_req) begin
                        wr_ack  <= 1'b0;
                        wr_fail <= 1'b0;
                        state   <= al_idle;
                    end
                end
                default: begin
                    state <= al_idle;
                end
            endcase
        end
    end

    // Request payload and the chosen bank.
    always_ff @(posedge clk) begin
        if ((state == al_idle) && wr_req) begin
            length_q <= wr_length;
            cells_q  <= {{(`SW_FREE_W-`SW_LEN_W+3){1'b0}}, wr_length[`SW_LEN_W-1:3]} + 1'b1;
        end
        if ((state == al_wait) && match_suc) begin
            wr_bank <= best_bank;
        end
    end

endmodule

`default_nettype wire

//--- bank_table_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

module bank_table_arbiter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_BANKS-1:0]  bank_disable,
    input  logic                  rel_valid,
    input  logic [`SW_BANK_W-1:0] rel_bank,
    input  logic [`SW_LEN_W-1:0]  rel_length,
    bank_scan_if.table_side       bus0,
    bank_scan_if.table_side       bus1
);

    localparam logic [`SW_FREE_W-1:0] bank_full = `SW_BANK_CELLS;
    localparam logic [`SW_CNT_W-1:0]  cnt_one   = 1;

    // Per-bank free cells and stored packet count.
    logic [`SW_FREE_W-1:0] bank_free  [`SW_BANKS];
    logic [`SW_CNT_W-1:0]  bank_count [`SW_BANKS];

    // Arbiter state.
    logic [`SW_PORTS-1:0] req;
    logic                 busy;
    logic                 owner;
    logic                 prio;

    // Updates seen this cycle.
    sram_switch_pkg::table_op_t com_op;
    sram_switch_pkg::table_op_t rel_op;
    logic [`SW_BANK_W-1:0]      com_bank;
    logic [`SW_FREE_W-1:0]      com_cells;
    logic [`SW_FREE_W-1:0]      rel_cells;
    logic [`SW_BANKS-1:0]       take_sel;
    logic [`SW_BANKS-1:0]       give_sel;

    assign req = {bus1.arb_req, bus0.arb_req};

    // Ack follows the held grant.
    assign bus0.arb_ack = busy && (owner == 1'b0);
    assign bus1.arb_ack = busy && (owner == 1'b1);

    // Round robin between the two ports.
    // Priority moves past the owner once its request falls.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (!busy) begin
            if (req[prio]) begin
                busy  <= 1'b1;
                owner <= prio;
            end else if (req[!prio]) begin
                busy  <= 1'b1;
                owner <= !prio;
            end
        end else if (!req[owner]) begin
            busy <= 1'b0;
            prio <= !owner;
        end
    end

    // Scan reads for each port.
    assign bus0.scan_status = '{accessible:    !bank_disable[bus0.scan_bank],
                                free_space:    bank_free[bus0.scan_bank],
                                packet_amount: bank_count[bus0.scan_bank]};
    assign bus1.scan_status = '{accessible:    !bank_disable[bus1.scan_bank],
                                free_space:    bank_free[bus1.scan_bank],
                                packet_amount: bank_count[bus1.scan_bank]};

    // Only the granted port may commit.
    always_comb begin
        com_op    = sram_switch_pkg::op_none;
        com_bank  = bus0.commit_bank;
        com_cells = bus0.commit_cells;
        if (busy) begin
            if (owner == 1'b0) begin
                com_op = bus0.commit_op;
            end else begin
                com_op    = bus1.commit_op;
                com_bank  = bus1.commit_bank;
                com_cells = bus1.commit_cells;
            end
        end
    end

    assign rel_op    = rel_valid ? sram_switch_pkg::op_release : sram_switch_pkg::op_none;
    assign rel_cells = {{(`SW_FREE_W-`SW_LEN_W+3){1'b0}}, rel_length[`SW_LEN_W-1:3]} + 1'b1;

    // Decode which bank each update touches.
    always_comb begin
        for (int i = 0; i < `SW_BANKS; i++) begin
            take_sel[i] = (com_op == sram_switch_pkg::op_commit)
                       && (com_bank == i[`SW_BANK_W-1:0]);
            give_sel[i] = (rel_op == sram_switch_pkg::op_release)
                       && (rel_bank == i[`SW_BANK_W-1:0]);
        end
    end

    // Commit and release on the same bank add up.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `SW_BANKS; i++) begin
                bank_free[i]  <= bank_full;
                bank_count[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `SW_BANKS; i++) begin
                bank_free[i]  <= bank_free[i]
                               - (take_sel[i] ? com_cells : '0)
                               + (give_sel[i] ? rel_cells : '0);
                bank_count[i] <= bank_count[i]
                               + (take_sel[i] ? cnt_one : '0)
                               - (give_sel[i] ? cnt_one : '0);
            end
        end
    end

endmodule

`default_nettype wire

//--- sram_switch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

module sram_switch_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`SW_BANK_W-1:0] scan_limit,
    input  logic [`SW_BANKS-1:0]  bank_disable,
    input  logic                  wr_req_0,
    input  logic [`SW_LEN_W-1:0]  wr_length_0,
    output logic                  wr_ack_0,
    output logic [`SW_BANK_W-1:0] wr_bank_0,
    output logic                  wr_fail_0,
    input  logic                  wr_req_1,
    input  logic [`SW_LEN_W-1:0]  wr_length_1,
    output logic                  wr_ack_1,
    output logic [`SW_BANK_W-1:0] wr_bank_1,
    output logic                  wr_fail_1,
    input  logic                  rel_valid,
    input  logic [`SW_BANK_W-1:0] rel_bank,
    input  logic [`SW_LEN_W-1:0]  rel_length
);

    // One table link per write port.
    bank_scan_if bus0 ();
    bank_scan_if bus1 ();

    port_wr_allocator i_port_wr_allocator_0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_limit (scan_limit),
        .wr_req     (wr_req_0),
        .wr_length  (wr_length_0),
        .wr_ack     (wr_ack_0),
        .wr_bank    (wr_bank_0),
        .wr_fail    (wr_fail_0),
        .bus        (bus0.port_side)
    );

    port_wr_allocator i_port_wr_allocator_1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .scan_limit (scan_limit),
        .wr_req     (wr_req_1),
        .wr_length  (wr_length_1),
        .wr_ack     (wr_ack_1),
        .wr_bank    (wr_bank_1),
        .wr_fail    (wr_fail_1),
        .bus        (bus1.port_side)
    );

    // Shared bank status table.
    bank_table_arbiter i_bank_table_arbiter (
        .clk          (clk),
        .rst_n        (rst_n),
        .bank_disable (bank_disable),
        .rel_valid    (rel_valid),
        .rel_bank     (rel_bank),
        .rel_length   (rel_length),
        .bus0         (bus0.table_side),
        .bus1         (bus1.table_side)
    );

endmodule

`default_nettype wire

//--- tb_sram_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "sram_switch_cfg.svh"

module tb_sram_switch;

    // Handshake wait limit, long enough for a full 32-bank scan.
    localparam int write_cycles = 48;
    // About 40 writes of up to 48 cycles each, plus reset.
    localparam int write_budget = 40;
    localparam int watchdog_ns  = 10 * (16 + write_budget * write_cycles) + 640;

    logic                  clk;
    logic                  rst_n;
    logic [`SW_BANK_W-1:0] scan_limit;
    logic [`SW_BANKS-1:0]  bank_disable;
    logic                  wr_req_0;
    logic [`SW_LEN_W-1:0]  wr_length_0;
    logic                  wr_ack_0;
    logic [`SW_BANK_W-1:0] wr_bank_0;
    logic                  wr_fail_0;
    logic                  wr_req_1;
    logic [`SW_LEN_W-1:0]  wr_length_1;
    logic                  wr_ack_1;
    logic [`SW_BANK_W-1:0] wr_bank_1;
    logic                  wr_fail_1;
    logic                  rel_valid;
    logic [`SW_BANK_W-1:0] rel_bank;
    logic [`SW_LEN_W-1:0]  rel_length;

    // Reference copy of the bank table.
    int                    model_free  [`SW_BANKS];
    int                    model_count [`SW_BANKS];
    int                    errors;
    int                    checks;
    int                    tests;
    logic [`SW_BANK_W-1:0] last_bank;
    logic                  last_fail;

    sram_switch_top i_sram_switch_top (.*);

    always #5 clk = ~clk;

    task automatic check_bank(input string name, input logic [`SW_BANK_W-1:0] got,
                              input logic [`SW_BANK_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_fail(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // Fullest qualifying bank up to the scan limit, later index on a tie.
    task automatic model_pick(input int len, output logic [`SW_BANK_W-1:0] bank,
                              output logic fail);
        int best;
        int need;
        need = len / 8 + 1;
        best = -1;
        for (int i = 0; i <= int'(scan_limit); i++) begin
            if (!bank_disable[i] && (model_free[i] >= need)
                && ((best < 0) || (model_count[i] >= model_count[best]))) begin
                best = i;
            end
        end
        fail = (best < 0);
        bank = fail ? '0 : best[`SW_BANK_W-1:0];
    endtask

    task automatic set_config(input logic [`SW_BANK_W-1:0] limit,
                              input logic [`SW_BANKS-1:0] dis);
        @(posedge clk);
        scan_limit   <= limit;
        bank_disable <= dis;
    endtask

    // Waits on falling edges so the DUT outputs are settled.
    task automatic wait_ack(input int port, input logic level);
        int n;
        n = 0;
        @(negedge clk);
        while ((((port == 0) ? wr_ack_0 : wr_ack_1) !== level) && (n < write_cycles)) begin
            @(negedge clk);
            n++;
        end
        if (((port == 0) ? wr_ack_0 : wr_ack_1) !== level) begin
            $display("port %0d: wr_ack did not go to %0b within %0d cycles",
                     port, level, write_cycles);
            errors++;
        end
    endtask

    // One full four-phase write, checked against the model.
    task automatic write_check(input int port, input int len);
        logic [`SW_BANK_W-1:0] exp_bank;
        logic                  exp_fail;
        @(posedge clk);
        // Configuration written on the previous edge is settled here.
        model_pick(len, exp_bank, exp_fail);
        if (port == 0) begin
            wr_req_0    <= 1'b1;
            wr_length_0 <= len[`SW_LEN_W-1:0];
        end else begin
            wr_req_1    <= 1'b1;
            wr_length_1 <= len[`SW_LEN_W-1:0];
        end
        wait_ack(port, 1'b1);
        last_bank = (port == 0) ? wr_bank_0 : wr_bank_1;
        last_fail = (port == 0) ? wr_fail_0 : wr_fail_1;
        check_fail((port == 0) ? "wr_fail_0" : "wr_fail_1", last_fail, exp_fail);
        if (!exp_fail) begin
            check_bank((port == 0) ? "wr_bank_0" : "wr_bank_1", last_bank, exp_bank);
            model_free[exp_bank]  -= len / 8 + 1;
            model_count[exp_bank] += 1;
        end
        @(posedge clk);
        if (port == 0) begin
            wr_req_0 <= 1'b0;
        end else begin
            wr_req_1 <= 1'b0;
        end
        wait_ack(port, 1'b0);
    endtask

    task automatic end_test(input string name, input int mark);
        tests++;
        if (errors == mark) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            $display("test %0d %s: %0d errors", tests, name, errors - mark);
        end
    endtask

    task automatic test_reset_first();
        int mark;
        mark = errors;
        @(negedge clk);
        check_fail("wr_ack_0", wr_ack_0, 1'b0);
        check_fail("wr_ack_1", wr_ack_1, 1'b0);
        check_fail("wr_fail_0", wr_fail_0, 1'b0);
        check_fail("wr_fail_1", wr_fail_1, 1'b0);
        // Empty table, every bank ties.
        set_config(5'd31, '0);
        write_check(0, 64);
        check_bank("wr_bank_0", last_bank, 5'd31);
        end_test("reset and first write", mark);
    endtask

    task automatic test_preference();
        int mark;
        mark = errors;
        set_config(5'd9, '0);
        for (int i = 0; i < 3; i++) begin
            write_check(i % 2, 100);
            check_bank("wr_bank", last_bank, 5'd9);
        end
        end_test("bank preference", mark);
    endtask

    task automatic test_disable_range();
        int mark;
        mark = errors;
        // Bank 9 is the fullest, so mask it.
        set_config(5'd9, 32'h0000_0200);
        write_check(1, 24);
        check_bank("wr_bank_1", last_bank, 5'd8);
        set_config(5'd3, '0);
        for (int i = 0; i < 2; i++) begin
            write_check(0, 8);
            if (last_bank > 5'd3) begin
                $display("error: wr_bank_0 0x%h lies above scan_limit 0x03", last_bank);
                errors++;
            end
        end
        end_test("disable and scan range", mark);
    endtask

    task automatic test_exhaustion();
        int mark;
        int n;
        mark = errors;
        set_config(5'd3, '0);
        n = 0;
        // A 511-byte packet takes 64 cells.
        while ((model_free[3] >= 64) && (n < 20)) begin
            write_check(n % 2, 511);
            n++;
        end
        write_check(0, 511);
        if (last_bank == 5'd3) begin
            $display("error: wr_bank_0 stayed at 0x03 after the bank ran out of cells");
            errors++;
        end
        set_config(5'd3, '1);
        write_check(1, 511);
        check_fail("wr_fail_1", last_fail, 1'b1);
        write_check(0, 511);
        check_fail("wr_fail_0", last_fail, 1'b1);
        set_config(5'd3, '0);
        end_test("space exhaustion", mark);
    endtask

    task automatic test_contention();
        int                    mark;
        int                    n;
        int                    p;
        int                    lens     [2];
        logic                  seen     [2];
        logic [`SW_BANK_W-1:0] got_bank [2];
        logic                  got_fail [2];
        int                    order    [$];
        logic [`SW_BANK_W-1:0] exp_bank;
        logic                  exp_fail;
        mark = errors;
        lens[0] = 40;
        lens[1] = 200;
        seen[0] = 1'b0;
        seen[1] = 1'b0;
        set_config(5'd9, '0);
        @(posedge clk);
        wr_req_0    <= 1'b1;
        wr_length_0 <= 9'd40;
        wr_req_1    <= 1'b1;
        wr_length_1 <= 9'd200;
        n = 0;
        // Record the acks in the order they rise.
        while ((order.size() < 2) && (n < 2 * write_cycles)) begin
            @(negedge clk);
            n++;
            for (int k = 0; k < 2; k++) begin
                if (!seen[k] && ((k == 0) ? wr_ack_0 : wr_ack_1)) begin
                    seen[k]     = 1'b1;
                    got_bank[k] = (k == 0) ? wr_bank_0 : wr_bank_1;
                    got_fail[k] = (k == 0) ? wr_fail_0 : wr_fail_1;
                    order.push_back(k);
                end
            end
        end
        if (order.size() < 2) begin
            $display("contention: only %0d of 2 ports acknowledged", order.size());
            errors++;
        end
        foreach (order[i]) begin
            p = order[i];
            model_pick(lens[p], exp_bank, exp_fail);
            check_fail((p == 0) ? "wr_fail_0" : "wr_fail_1", got_fail[p], exp_fail);
            if (!exp_fail) begin
                check_bank((p == 0) ? "wr_bank_0" : "wr_bank_1", got_bank[p], exp_bank);
                model_free[exp_bank]  -= lens[p] / 8 + 1;
                model_count[exp_bank] += 1;
            end
        end
        @(posedge clk);
        wr_req_0 <= 1'b0;
        wr_req_1 <= 1'b0;
        wait_ack(0, 1'b0);
        wait_ack(1, 1'b0);
        end_test("contention", mark);
    endtask

    task automatic test_release();
        int mark;
        int b;
        int n;
        mark = errors;
        set_config(5'd9, '0);
        b = 0;
        for (int i = 1; i <= 9; i++) begin
            if (model_count[i] >= model_count[b]) begin
                b = i;
            end
        end
        // Leave one packet behind in the fullest bank.
        n = model_count[b] - 1;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            rel_valid  <= 1'b1;
            rel_bank   <= b[`SW_BANK_W-1:0];
            rel_length <= 9'd511;
            model_free[b]  += 511 / 8 + 1;
            model_count[b] -= 1;
        end
        @(posedge clk);
        rel_valid <= 1'b0;
        write_check(0, 16);
        if ((n > 0) && (last_bank == b[`SW_BANK_W-1:0])) begin
            $display("error: wr_bank_0 stayed at 0x%h after its packets were released",
                     last_bank);
            errors++;
        end
        end_test("release", mark);
    endtask

    initial begin
        $display("watchdog armed at %0d ns", watchdog_ns);
        #(watchdog_ns);
        $display("watchdog: the run did not finish within %0d ns", watchdog_ns);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        scan_limit   = '0;
        bank_disable = '0;
        wr_req_0     = 1'b0;
        wr_length_0  = '0;
        wr_req_1     = 1'b0;
        wr_length_1  = '0;
        rel_valid    = 1'b0;
        rel_bank     = '0;
        rel_length   = '0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        for (int i = 0; i < `SW_BANKS; i++) begin
            model_free[i]  = `SW_BANK_CELLS;
            model_count[i] = 0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_first();
        test_preference();
        test_disable_range();
        test_exhaustion();
        test_contention();
        test_release();
        $display("tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sram_switch.f
+incdir+.
sram_switch_pkg.sv
bank_scan_if.sv
port_wr_sram_matcher.sv
port_wr_allocator.sv
bank_table_arbiter.sv
sram_switch_top.sv
tb_sram_switch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log for the pass line.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sram_switch \
    -f sram_switch.f -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "build or run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx "=== PASS ===" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
